// File: compile.f
src/lsu_pkg.sv
src/lutram_dualport.sv
src/lsu_decode.sv
src/lsu_execute.sv
src/lsu_result.sv
src/lsu_top.sv
dv/lsu_tb.sv

// File: dv/lsu_patterns.txt
// columns: cmd wdata exp_valid exp_err exp_tag exp_data, all hex
// loads after reset read zero
6003 00000000 1 0 3 00000000
5105 00000000 1 0 5 00000000
4F1E 00000000 1 0 6 00000000
// word store then every extension form
A200 F1E2D3C4 0 0 0 00000000
6201 00000000 1 0 1 F1E2D3C4
421A 00000000 1 0 2 FFFFFFD3
4212 00000000 1 0 2 000000D3
522C 00000000 1 0 4 FFFFF1E2
5224 00000000 1 0 4 0000F1E2
4208 00000000 1 0 0 FFFFFFC4
// byte and half stores
8310 1234565A 0 0 0 00000000
9360 ABCD8001 0 0 0 00000000
6307 00000000 1 0 7 00005A00
6341 00000000 1 0 1 80010000
536B 00000000 1 0 3 FFFF8001
431D 00000000 1 0 5 0000005A
9300 00007FFE 0 0 0 00000000
6302 00000000 1 0 2 00007FFE
8330 000000A5 0 0 0 00000000
6304 00000000 1 0 4 A5007FFE
// masked stores keep the other lanes
A400 11223344 0 0 0 00000000
B405 AABBCCDD 0 0 0 00000000
6406 00000000 1 0 6 11BB33DD
B408 9900FFEE 0 0 0 00000000
6400 00000000 1 0 0 99BB33DD
// misaligned accesses, store errors carry tag 0
5213 00000000 1 1 3 00000000
622D 00000000 1 1 5 00000000
9417 FFFFFFFF 1 1 0 00000000
A43F 00000000 1 1 0 00000000
B42F 00000000 1 1 0 00000000
6404 00000000 1 0 4 99BB33DD
0400 DEADBEEF 0 0 0 00000000
E400 00000000 0 0 0 00000000
6402 00000000 1 0 2 99BB33DD

// File: dv/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

	localparam int READ_LATENCY = 1;
	localparam int LATENCY = 2 + READ_LATENCY;
	localparam int CLK_PERIOD = 40;
	localparam int N_RANDOM = 400;
	localparam int MAX_PAT = 64;
	localparam int COLS = 6;	// words per pattern line

	logic clk;
	logic resetn;
	logic cmd_valid;
	lsu_cmd_t cmd;
	logic [DATA_W-1:0] wdata;
	logic rsp_valid;
	logic rsp_err;
	lsu_tag_t rsp_tag;
	logic [DATA_W-1:0] rsp_data;

	logic [7:0] model_mem [256];	// byte image of the scratchpad
	logic [31:0] pat_words [MAX_PAT*COLS];
	int n_pat = 0;
	logic patterns_ready = 1'b0;
	int cycle_count = 0;
	logic [31:0] lcg_state = 32'd84771;

	logic exp_err_q [$];
	lsu_tag_t exp_tag_q [$];
	logic [DATA_W-1:0] exp_data_q [$];
	int exp_cycle_q [$];

	lsu_top #(
		.DATA_W(DATA_W), .LANES(LANES), .ADDR_W(ADDR_W), .READ_LATENCY(READ_LATENCY)
	) lsu_top_inst (
		.clk, .resetn, .cmd_valid, .cmd, .wdata,
		.rsp_valid, .rsp_err, .rsp_tag, .rsp_data
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	always @(posedge clk) cycle_count <= cycle_count + 1;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic abort_run();
		$display("ERRORS FOUND");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_load(input lsu_tag_t got_tag, input logic [DATA_W-1:0] got_data,
			input lsu_tag_t exp_tag, input logic [DATA_W-1:0] exp_data);
		if (got_tag !== exp_tag || got_data !== exp_data) begin
			$display("ERR %0t: response tag %0h data %08h, expected tag %0h data %08h",
				$time, got_tag, got_data, exp_tag, exp_data);
			abort_run();
		end
	endtask

	task automatic check_err(input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %0t: rsp_err %b, expected %b", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic check_latency(input int got_cycle, input int exp_cycle);
		if (got_cycle != exp_cycle) begin
			$display("ERR %0t: response in cycle %0d, expected cycle %0d",
				$time, got_cycle, exp_cycle);
			abort_run();
		end
	endtask

	task automatic send_cmd(input lsu_cmd_t c, input logic [DATA_W-1:0] wd,
			output int sample_cycle);
		@(posedge clk);
		#2;
		cmd_valid = 1'b1;
		cmd = c;
		wdata = wd;
		sample_cycle = cycle_count + 1;	// edge that samples it
	endtask

	task automatic push_expect(input logic err, input lsu_tag_t tag,
			input logic [DATA_W-1:0] data, input int sample_cycle);
		exp_err_q.push_back(err);
		exp_tag_q.push_back(tag);
		exp_data_q.push_back(data);
		exp_cycle_q.push_back(sample_cycle + LATENCY);
	endtask

	// applies one command to the byte image and predicts its response
	task automatic run_model(input lsu_cmd_t c, input logic [DATA_W-1:0] wd,
			output logic has_rsp, output logic err, output lsu_tag_t tag,
			output logic [DATA_W-1:0] data);
		logic [7:0] a;
		logic bad;
		a = c.ld.addr;
		has_rsp = 1'b0;
		err = 1'b0;
		tag = '0;
		data = '0;
		case (c.ld.size)
			SIZE_BYTE: bad = 1'b0;
			SIZE_HALF: bad = a[0];
			default: bad = a[1:0] != 2'b00;
		endcase
		if (c.ld.op == OP_LOAD) begin
			has_rsp = 1'b1;
			err = bad;
			tag = c.ld.tag;
			if (!bad) begin
				case (c.ld.size)
					SIZE_BYTE: data = {{24{c.ld.sgn & model_mem[a][7]}}, model_mem[a]};
					SIZE_HALF: data = {{16{c.ld.sgn & model_mem[a+1][7]}},
						model_mem[a+1], model_mem[a]};
					default: data = {model_mem[a+3], model_mem[a+2], model_mem[a+1], model_mem[a]};
				endcase
			end
		end else if (c.st.op == OP_STORE) begin
			if (bad) begin
				has_rsp = 1'b1;
				err = 1'b1;
			end else begin
				for (int i = 0; i < 4; i++) begin
					case (c.st.size)
						SIZE_BYTE: if (i == 0) model_mem[a] = wd[7:0];
						SIZE_HALF: if (i < 2) model_mem[a+i] = wd[8*i +: 8];
						SIZE_WORD: model_mem[a+i] = wd[8*i +: 8];
						default: if (c.st.mask[i]) model_mem[a+i] = wd[8*i +: 8];
					endcase
				end
			end
		end
	endtask

	task automatic random_cmd(output lsu_cmd_t c, output logic [DATA_W-1:0] wd);
		logic [31:0] r;
		logic [7:0] a;
		lsu_size_e sz;
		logic is_load;
		r = lcg_next();
		wd = lcg_next();
		is_load = r[31:28] < 4'd7;
		sz = lsu_size_e'(r[27:26]);
		if (is_load && sz == SIZE_MASKED) sz = SIZE_WORD;	// masked is a store form
		a = r[25:18];
		if (r[16]) a[7:5] = 3'd0;	// narrow window for more hits on stored data
		if (r[17]) begin
			if (sz == SIZE_HALF) a[0] = 1'b0;
			else if (sz != SIZE_BYTE) a[1:0] = 2'b00;
		end
		c = '0;
		c.ld.size = sz;
		c.ld.addr = a;
		if (r[31:28] == 4'hf) begin
			c.ld.op = OP_NOP;
		end else if (is_load) begin
			c.ld.op = OP_LOAD;
			c.ld.sgn = r[15];
			c.ld.tag = r[14:12];
		end else begin
			c.st.op = OP_STORE;
			c.st.mask = r[15:12];
		end
	endtask

	// response monitor
	initial begin
		forever begin
			@(negedge clk);
			if (resetn === 1'b1) begin
				if ($isunknown(rsp_valid)) begin
					$display("rsp_valid is unknown at %0t", $time);
					abort_run();
				end else if (rsp_valid) begin
					if (exp_cycle_q.size() == 0) begin
						$display("a response came at %0t while no command was waiting for one",
							$time);
						abort_run();
					end else begin
						check_latency(cycle_count, exp_cycle_q.pop_front());
						check_err(rsp_err, exp_err_q.pop_front());
						check_load(rsp_tag, rsp_data, exp_tag_q.pop_front(), exp_data_q.pop_front());
					end
				end
			end
		end
	end

	initial begin
		int limit_ns;
		wait (patterns_ready);
		limit_ns = (n_pat + N_RANDOM + 20) * CLK_PERIOD;
		#(limit_ns);
		$display("timeout: the run did not finish within %0d ns", limit_ns);
		abort_run();
	end

	initial begin
		lsu_cmd_t c;
		logic [DATA_W-1:0] wd;
		int at;
		logic has_rsp;
		logic m_err;
		lsu_tag_t m_tag;
		logic [DATA_W-1:0] m_data;
		resetn = 1'b0;
		cmd_valid = 1'b0;
		cmd = '0;
		wdata = '0;
		for (int i = 0; i < 256; i++) model_mem[i] = 8'h00;
		for (int i = 0; i < MAX_PAT*COLS; i++) pat_words[i] = 32'hff00_0000 | 32'(i);
		$readmemh("dv/lsu_patterns.txt", pat_words);
		while (n_pat < MAX_PAT && pat_words[COLS*n_pat][31:16] == 16'h0) n_pat++;
		patterns_ready = 1'b1;
		if (n_pat == 0) begin
			$display("no pattern lines could be read from dv/lsu_patterns.txt");
			abort_run();
		end
		repeat (10) @(posedge clk);
		#2;
		resetn = 1'b1;

		for (int i = 0; i < n_pat; i++) begin
			c = pat_words[COLS*i][15:0];
			wd = pat_words[COLS*i+1];
			send_cmd(c, wd, at);
			run_model(c, wd, has_rsp, m_err, m_tag, m_data);	// keeps the image in step
			if (pat_words[COLS*i+2][0]) begin
				push_expect(pat_words[COLS*i+3][0], pat_words[COLS*i+4][TAG_W-1:0],
					pat_words[COLS*i+5], at);
			end
		end

		for (int n = 0; n < N_RANDOM; n++) begin
			random_cmd(c, wd);
			send_cmd(c, wd, at);
			run_model(c, wd, has_rsp, m_err, m_tag, m_data);
			if (has_rsp) push_expect(m_err, m_tag, m_data, at);
		end

		@(posedge clk);
		#2;
		cmd_valid = 1'b0;
		cmd = '0;
		wdata = '0;
		while (exp_cycle_q.size() != 0) @(posedge clk);
		repeat (2) @(posedge clk);
		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; #(
	parameter int DATA_W = lsu_pkg::DATA_W,
	parameter int LANES = lsu_pkg::LANES,
	parameter int ADDR_W = lsu_pkg::ADDR_W,
	parameter int READ_LATENCY = 1,
	localparam int LANE_W = $clog2(LANES)
) (
	input logic clk,
	input logic resetn,
	input logic cmd_valid,
	input lsu_cmd_t cmd,
	input logic [DATA_W-1:0] wdata,
	output logic rsp_valid,
	output logic rsp_err,
	output lsu_tag_t rsp_tag,
	output logic [DATA_W-1:0] rsp_data
);

	logic dec_valid, dec_is_load, dec_err, dec_signed;
	logic [ADDR_W-1:0] dec_word_addr;
	logic [LANE_W-1:0] dec_lane;
	lsu_size_e dec_size;
	lsu_tag_t dec_tag;
	logic [LANES-1:0] dec_strobe;
	logic [DATA_W-1:0] dec_wdata;

	logic en_1, en_2;
	logic [ADDR_W-1:0] addr_1, addr_2;
	logic [LANES-1:0] strobe;
	logic [DATA_W-1:0] wr_data, rdata_2;

	logic ex_valid, ex_err, ex_signed;
	logic [LANE_W-1:0] ex_lane;
	lsu_size_e ex_size;
	lsu_tag_t ex_tag;

	lsu_decode #(.DATA_W(DATA_W), .LANES(LANES), .ADDR_W(ADDR_W)) lsu_decode_inst (.*);

	lsu_execute #(
		.DATA_W(DATA_W), .LANES(LANES), .ADDR_W(ADDR_W), .READ_LATENCY(READ_LATENCY)
	) lsu_execute_inst (.*);

	lutram_dualport #(
		.ADDR_W(ADDR_W), .DATA_W(DATA_W), .BYTE_W(DATA_W / LANES),
		.READ_LATENCY(READ_LATENCY)
	) lutram_dualport_inst (
		.clk, .resetn, .en_1, .en_2, .addr_1, .addr_2, .strobe,
		.wdata(wr_data),
		.rdata_1(),	// port 1 is write only here
		.rdata_2
	);

	lsu_result #(.DATA_W(DATA_W), .LANES(LANES)) lsu_result_inst (
		.clk, .resetn,
		.rdata(rdata_2),
		.ex_valid, .ex_err, .ex_lane, .ex_size, .ex_signed, .ex_tag,
		.rsp_valid, .rsp_err, .rsp_tag, .rsp_data
	);

endmodule

`default_nettype wire

// File: src/lsu_result.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_result import lsu_pkg::*; #(
	parameter int DATA_W = lsu_pkg::DATA_W,
	parameter int LANES = lsu_pkg::LANES,
	localparam int LANE_W = $clog2(LANES),
	localparam int BYTE_W = DATA_W / LANES
) (
	input logic clk,
	input logic resetn,
	input logic [DATA_W-1:0] rdata,
	input logic ex_valid,
	input logic ex_err,
	input logic [LANE_W-1:0] ex_lane,
	input lsu_size_e ex_size,
	input logic ex_signed,
	input lsu_tag_t ex_tag,
	output logic rsp_valid,
	output logic rsp_err,
	output lsu_tag_t rsp_tag,
	output logic [DATA_W-1:0] rsp_data
);

	logic [DATA_W-1:0] shifted;
	logic [DATA_W-1:0] ext;
	logic sign_b;
	logic sign_h;

	assign shifted = rdata >> (ex_lane * BYTE_W);	// addressed byte down to lane 0
	assign sign_b = ex_signed & shifted[BYTE_W-1];
	assign sign_h = ex_signed & shifted[2*BYTE_W-1];

	always_comb begin
		case (ex_size)
			SIZE_BYTE: ext = {{(DATA_W-BYTE_W){sign_b}}, shifted[BYTE_W-1:0]};
			SIZE_HALF: ext = {{(DATA_W-2*BYTE_W){sign_h}}, shifted[2*BYTE_W-1:0]};
			default: ext = shifted;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			rsp_valid <= 1'b0;
			rsp_err <= 1'b0;
		end else begin
			rsp_valid <= ex_valid;
			rsp_err <= ex_valid & ex_err;
		end
	end

	// idle cycles show zeros on tag and data
	always_ff @(posedge clk) begin
		rsp_tag <= ex_valid ? ex_tag : '0;
		rsp_data <= (ex_valid && !ex_err) ? ext : '0;
	end

endmodule

`default_nettype wire

// File: src/lsu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_execute import lsu_pkg::*; #(
	parameter int DATA_W = lsu_pkg::DATA_W,
	parameter int LANES = lsu_pkg::LANES,
	parameter int ADDR_W = lsu_pkg::ADDR_W,
	parameter int READ_LATENCY = 1,
	localparam int LANE_W = $clog2(LANES),
	localparam int BYTE_W = DATA_W / LANES
) (
	input logic clk,
	input logic resetn,
	input logic dec_valid,
	input logic dec_is_load,
	input logic dec_err,
	input logic [ADDR_W-1:0] dec_word_addr,
	input logic [LANE_W-1:0] dec_lane,
	input lsu_size_e dec_size,
	input logic dec_signed,
	input lsu_tag_t dec_tag,
	input logic [LANES-1:0] dec_strobe,
	input logic [DATA_W-1:0] dec_wdata,
	output logic en_1,
	output logic [ADDR_W-1:0] addr_1,
	output logic [LANES-1:0] strobe,
	output logic [DATA_W-1:0] wr_data,
	output logic en_2,
	output logic [ADDR_W-1:0] addr_2,
	output logic ex_valid,
	output logic ex_err,
	output logic [LANE_W-1:0] ex_lane,
	output lsu_size_e ex_size,
	output logic ex_signed,
	output lsu_tag_t ex_tag
);

	logic [DATA_W-1:0] lane_data;

	// stage 0 lines up with the RAM address, stage READ_LATENCY with rdata
	logic [READ_LATENCY:0] valid_q;
	logic err_q [READ_LATENCY+1];
	logic [LANE_W-1:0] lane_q [READ_LATENCY+1];
	lsu_size_e size_q [READ_LATENCY+1];
	logic signed_q [READ_LATENCY+1];
	lsu_tag_t tag_q [READ_LATENCY+1];

	// spread narrow store data over every lane, strobe picks the right one
	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			case (dec_size)
				SIZE_BYTE: lane_data[i*BYTE_W +: BYTE_W] = dec_wdata[BYTE_W-1:0];
				SIZE_HALF: lane_data[i*BYTE_W +: BYTE_W] = dec_wdata[(i%2)*BYTE_W +: BYTE_W];
				default: lane_data[i*BYTE_W +: BYTE_W] = dec_wdata[i*BYTE_W +: BYTE_W];
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			en_1 <= 1'b0;
			en_2 <= 1'b0;
			valid_q[0] <= 1'b0;
		end else begin
			en_1 <= dec_valid & ~dec_is_load & ~dec_err;
			en_2 <= dec_valid & dec_is_load & ~dec_err;
			valid_q[0] <= dec_valid & (dec_is_load | dec_err);	// loads and bad stores answer
		end
	end

	always_ff @(posedge clk) begin
		addr_1 <= dec_word_addr;
		addr_2 <= dec_word_addr;
		strobe <= dec_strobe;
		wr_data <= lane_data;
		err_q[0] <= dec_err;
		lane_q[0] <= dec_lane;
		size_q[0] <= dec_size;
		signed_q[0] <= dec_signed;
		tag_q[0] <= dec_tag;
	end

	for (genvar i = 1; i <= READ_LATENCY; i++) begin : g_delay
		always_ff @(posedge clk) begin
			if (!resetn) begin
				valid_q[i] <= 1'b0;
			end else begin
				valid_q[i] <= valid_q[i-1];
			end
		end

		always_ff @(posedge clk) begin
			err_q[i] <= err_q[i-1];
			lane_q[i] <= lane_q[i-1];
			size_q[i] <= size_q[i-1];
			signed_q[i] <= signed_q[i-1];
			tag_q[i] <= tag_q[i-1];
		end
	end

	assign ex_valid = valid_q[READ_LATENCY];
	assign ex_err = err_q[READ_LATENCY];
	assign ex_lane = lane_q[READ_LATENCY];
	assign ex_size = size_q[READ_LATENCY];
	assign ex_signed = signed_q[READ_LATENCY];
	assign ex_tag = tag_q[READ_LATENCY];

endmodule

`default_nettype wire

// File: src/lsu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_decode import lsu_pkg::*; #(
	parameter int DATA_W = lsu_pkg::DATA_W,
	parameter int LANES = lsu_pkg::LANES,
	parameter int ADDR_W = lsu_pkg::ADDR_W,
	localparam int LANE_W = $clog2(LANES)
) (
	input logic clk,
	input logic resetn,
	input logic cmd_valid,
	input lsu_cmd_t cmd,
	input logic [DATA_W-1:0] wdata,
	output logic dec_valid,
	output logic dec_is_load,
	output logic dec_err,
	output logic [ADDR_W-1:0] dec_word_addr,
	output logic [LANE_W-1:0] dec_lane,
	output lsu_size_e dec_size,
	output logic dec_signed,
	output lsu_tag_t dec_tag,
	output logic [LANES-1:0] dec_strobe,
	output logic [DATA_W-1:0] dec_wdata
);

	logic is_load;
	logic is_store;
	logic misaligned;
	logic [LANE_W-1:0] lane;
	logic [LANES-1:0] lanes_en;

	assign is_load = cmd.ld.op == OP_LOAD;
	assign is_store = cmd.st.op == OP_STORE;
	assign lane = cmd.ld.addr[LANE_W-1:0];

	always_comb begin
		misaligned = 1'b0;
		lanes_en = '0;
		case (cmd.ld.size)
			SIZE_BYTE: lanes_en[lane] = 1'b1;
			SIZE_HALF: begin
				misaligned = lane[0];
				lanes_en = LANES'(2'b11) << lane;
			end
			SIZE_WORD: begin
				misaligned = |lane;
				lanes_en = '1;
			end
			default: begin
				misaligned = |lane;
				lanes_en = is_store ? LANES'(cmd.st.mask) : '1;	// masked load reads a word
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= cmd_valid & (is_load | is_store);	// nop and unknown ops dropped
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			dec_is_load <= is_load;
			dec_err <= misaligned;
			dec_word_addr <= cmd.ld.addr[LANE_W +: ADDR_W];
			dec_lane <= lane;
			dec_size <= cmd.ld.size;
			dec_signed <= is_load & cmd.ld.sgn;
			dec_tag <= is_load ? cmd.ld.tag : '0;	// store errors answer with tag 0
			dec_strobe <= lanes_en;
			dec_wdata <= wdata;
		end
	end

endmodule

`default_nettype wire

// File: src/lutram_dualport.sv
`timescale 1ns/1ps
`default_nettype none

module lutram_dualport #(
	parameter int ADDR_W = 6,
	parameter int DATA_W = 32,
	parameter int BYTE_W = 8,
	parameter int READ_LATENCY = 1,
	localparam int LANES = DATA_W / BYTE_W,
	localparam int WORDS = 2 ** ADDR_W
) (
	input logic clk,
	input logic resetn,
	input logic en_1,
	input logic en_2,
	input logic [ADDR_W-1:0] addr_1,
	input logic [ADDR_W-1:0] addr_2,
	input logic [LANES-1:0] strobe,
	input logic [DATA_W-1:0] wdata,
	output logic [DATA_W-1:0] rdata_1,
	output logic [DATA_W-1:0] rdata_2
);

	typedef union packed {
		logic [DATA_W-1:0] word;
		logic [LANES-1:0][BYTE_W-1:0] lanes;
	} ram_word_t;

	ram_word_t mem [WORDS];
	ram_word_t wr_word;

	// both read ports share one pipeline description
	logic en [2];
	logic [ADDR_W-1:0] addr [2];
	logic [DATA_W-1:0] rdata [2];

	assign wr_word = wdata;
	assign en[0] = en_1;
	assign en[1] = en_2;
	assign addr[0] = addr_1;
	assign addr[1] = addr_2;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			for (int i = 0; i < WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (en_1) begin
			for (int i = 0; i < LANES; i++) begin
				if (strobe[i]) begin
					mem[addr_1].lanes[i] <= wr_word.lanes[i];
				end
			end
		end
	end

	for (genvar p = 0; p < 2; p++) begin : g_port
		if (READ_LATENCY == 0) begin : g_comb
			assign rdata[p] = mem[addr[p]].word;	// async read
		end else begin : g_pipe
			logic [DATA_W-1:0] pipe [READ_LATENCY];

			always_ff @(posedge clk) begin
				if (en[p]) begin
					pipe[0] <= mem[addr[p]].word;
				end
				for (int s = 1; s < READ_LATENCY; s++) begin
					pipe[s] <= pipe[s-1];
				end
			end

			assign rdata[p] = pipe[READ_LATENCY-1];
		end
	end

	assign rdata_1 = rdata[0];
	assign rdata_2 = rdata[1];

endmodule

`default_nettype wire

// File: src/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

	// default sizes
	parameter int DATA_W = 32;
	parameter int LANES = 4;
	parameter int ADDR_W = 6;	// word address bits

	// command word fields
	parameter int OP_W = 2;
	parameter int SIZE_W = 2;
	parameter int BADDR_W = 8;
	parameter int TAG_W = 3;
	parameter int MASK_W = 4;

	typedef enum logic [OP_W-1:0] {
		OP_NOP = 2'd0,
		OP_LOAD = 2'd1,
		OP_STORE = 2'd2
	} lsu_op_e;

	typedef enum logic [SIZE_W-1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2,
		SIZE_MASKED = 2'd3	// stores only
	} lsu_size_e;

	typedef logic [TAG_W-1:0] lsu_tag_t;

	// both views share the upper fields and differ in the low nibble
	typedef union packed {
		struct packed {
			lsu_op_e op;
			lsu_size_e size;
			logic [BADDR_W-1:0] addr;
			logic sgn;
			lsu_tag_t tag;
		} ld;
		struct packed {
			lsu_op_e op;
			lsu_size_e size;
			logic [BADDR_W-1:0] addr;
			logic [MASK_W-1:0] mask;
		} st;
	} lsu_cmd_t;

endpackage

`default_nettype wire
